/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    parameter int unsigned XLEN = 64;

    typedef logic [31:0] instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASSB   // operand b straight through, for lui
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA
    } fetch_state_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_t          instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_t          instr;
        logic [4:0]      rs1_idx;
        logic [4:0]      rs2_idx;
        logic [4:0]      rd_idx;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic            use_imm;
        alu_op_e         alu_op;
        br_kind_e        br_kind;
        logic            wb_en;
    } id_ex_t;

    // writeback bundle, doubles as commit trace
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_t          instr;
        logic [4:0]      rd_idx;
        logic            wb_en;
        logic [XLEN-1:0] result;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* src/fetch_axi.sv */
`default_nettype none

module fetch_axi import core_pkg::*; #(
    parameter int unsigned     AXI_ADDR_WIDTH = 64,
    parameter int unsigned     AXI_ID_WIDTH   = 4,
    parameter logic [XLEN-1:0] RESET_PC       = '0
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n_i,
    input  redirect_t                      redirect_i,
    input  wire logic                      axi_ar_ready_i,
    output logic                           axi_ar_valid_o,
    output logic [AXI_ADDR_WIDTH-1:0]      axi_ar_addr_o,
    output logic [AXI_ID_WIDTH-1:0]        axi_ar_id_o,
    input  wire logic                      axi_r_valid_i,
    output logic                           axi_r_ready_o,
    input  wire logic [63:0]               axi_r_data_i,
    output if_id_t                         if_id_o
);

    fetch_state_e    state_q, state_d;
    logic [XLEN-1:0] pc_q, pc_d;    // address of the request in flight
    logic            stale_q, stale_d;
    logic [XLEN-1:0] tgt_q, tgt_d;  // where to go once a stale beat is gone

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        stale_d = stale_q;
        tgt_d   = tgt_q;
        case (state_q)
            F_IDLE: begin
                state_d = F_ADDR;
            end
            F_ADDR: begin
                if (axi_ar_ready_i) begin
                    state_d = F_DATA;
                end
                // address must stay stable, so remember the target instead
                if (redirect_i.valid) begin
                    stale_d = 1'b1;
                    tgt_d   = redirect_i.target;
                end
            end
            F_DATA: begin
                if (axi_r_valid_i) begin
                    state_d = F_ADDR;
                    stale_d = 1'b0;
                    if (redirect_i.valid) begin
                        pc_d = redirect_i.target;
                    end else if (stale_q) begin
                        pc_d = tgt_q;
                    end else begin
                        pc_d = pc_q + XLEN'(4);
                    end
                end else if (redirect_i.valid) begin
                    stale_d = 1'b1;
                    tgt_d   = redirect_i.target;
                end
            end
            default: state_d = F_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= F_IDLE;
            pc_q    <= RESET_PC;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            stale_q <= stale_d;
        end
    end

    always_ff @(posedge clk) begin
        tgt_q <= tgt_d;
    end

    assign axi_ar_valid_o = (state_q == F_ADDR);
    assign axi_ar_addr_o  = AXI_ADDR_WIDTH'(pc_q);  // trunc or zero-extend
    assign axi_ar_id_o    = '0;
    assign axi_r_ready_o  = (state_q == F_DATA);

    // doubleword beat, pick the word by pc bit 2
    assign if_id_o.valid = (state_q == F_DATA) & axi_r_valid_i & ~stale_q;
    assign if_id_o.pc    = pc_q;
    assign if_id_o.instr = pc_q[2] ? axi_r_data_i[63:32] : axi_r_data_i[31:0];

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n_i,
    input  if_id_t          if_id_i,
    input  redirect_t       redirect_i,
    input  wb_t             wb_i,
    output id_ex_t          id_ex_o,
    output logic [XLEN-1:0] reg_a0_o
);

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    logic            id_valid_q;
    if_id_t          id_q;        // payload only, valid lives in id_valid_q
    logic [XLEN-1:0] rf_q [1:31];
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u;

    function automatic logic [XLEN-1:0] rf_read(input logic [4:0] idx);
        logic [XLEN-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (wb_i.valid && wb_i.wb_en && wb_i.rd_idx == idx) begin
            val = wb_i.result;  // write-through
        end else begin
            val = rf_q[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= if_id_i.valid & ~redirect_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        id_q <= if_id_i;
    end

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.wb_en && wb_i.rd_idx != 5'd0) begin
            rf_q[wb_i.rd_idx] <= wb_i.result;
        end
    end

    assign reg_a0_o = rf_q[10];

    assign opcode = opcode_e'(id_q.instr[6:0]);
    assign funct3 = id_q.instr[14:12];

    assign imm_i = {{52{id_q.instr[31]}}, id_q.instr[31:20]};
    assign imm_b = {{51{id_q.instr[31]}}, id_q.instr[31], id_q.instr[7],
                    id_q.instr[30:25], id_q.instr[11:8], 1'b0};
    assign imm_j = {{43{id_q.instr[31]}}, id_q.instr[31], id_q.instr[19:12],
                    id_q.instr[20], id_q.instr[30:21], 1'b0};
    assign imm_u = {{32{id_q.instr[31]}}, id_q.instr[31:12], 12'b0};  // rv64 sign-extends

    always_comb begin
        id_ex_o         = '0;
        id_ex_o.valid   = id_valid_q;
        id_ex_o.pc      = id_q.pc;
        id_ex_o.instr   = id_q.instr;
        id_ex_o.rs1_idx = id_q.instr[19:15];
        id_ex_o.rs2_idx = id_q.instr[24:20];
        id_ex_o.rd_idx  = id_q.instr[11:7];
        id_ex_o.rs1_val = rf_read(id_q.instr[19:15]);
        id_ex_o.rs2_val = rf_read(id_q.instr[24:20]);
        id_ex_o.alu_op  = ALU_ADD;
        id_ex_o.br_kind = BR_NONE;
        case (opcode)
            OPC_OP_IMM: begin
                id_ex_o.imm     = imm_i;
                id_ex_o.use_imm = 1'b1;
                id_ex_o.wb_en   = (funct3 == 3'b000);  // only addi
            end
            OPC_OP: begin
                id_ex_o.wb_en = 1'b1;
                case (funct3)
                    3'b000:  id_ex_o.alu_op = id_q.instr[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  id_ex_o.alu_op = ALU_XOR;
                    3'b110:  id_ex_o.alu_op = ALU_OR;
                    3'b111:  id_ex_o.alu_op = ALU_AND;
                    default: id_ex_o.wb_en  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                id_ex_o.imm     = imm_u;
                id_ex_o.use_imm = 1'b1;
                id_ex_o.alu_op  = ALU_PASSB;
                id_ex_o.wb_en   = 1'b1;
            end
            OPC_BRANCH: begin
                id_ex_o.imm = imm_b;
                if (funct3 == 3'b000) begin
                    id_ex_o.br_kind = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    id_ex_o.br_kind = BR_NE;
                end
            end
            OPC_JAL: begin
                id_ex_o.imm     = imm_j;
                id_ex_o.br_kind = BR_JAL;
                id_ex_o.wb_en   = 1'b1;  // link value comes from execute
            end
            default: ;  // unknown, commits as nop
        endcase
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n_i,
    input  id_ex_t    id_ex_i,
    output redirect_t redirect_o,
    output wb_t       wb_o
);

    logic            ex_valid_q;
    id_ex_t          ex_q;
    logic            wb_valid_q;
    wb_t             wb_q;
    logic [XLEN-1:0] op_a, op_b, rs2_fwd;
    logic [XLEN-1:0] alu_res;
    logic            taken;
    wb_t             wb_d;

    // pick the wb result over the value read in decode
    function automatic logic [XLEN-1:0] fwd(input logic [4:0] idx,
                                            input logic [XLEN-1:0] val);
        logic hit;
        hit = wb_o.valid && wb_o.wb_en && wb_o.rd_idx != 5'd0
              && idx != 5'd0 && wb_o.rd_idx == idx;
        return hit ? wb_o.result : val;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= id_ex_i.valid & ~redirect_o.valid;  // flush younger
            wb_valid_q <= wb_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_q <= id_ex_i;
        wb_q <= wb_d;
    end

    always_comb begin
        op_a    = fwd(ex_q.rs1_idx, ex_q.rs1_val);
        rs2_fwd = fwd(ex_q.rs2_idx, ex_q.rs2_val);
        op_b    = ex_q.use_imm ? ex_q.imm : rs2_fwd;
        case (ex_q.alu_op)
            ALU_SUB:   alu_res = op_a - op_b;
            ALU_AND:   alu_res = op_a & op_b;
            ALU_OR:    alu_res = op_a | op_b;
            ALU_XOR:   alu_res = op_a ^ op_b;
            ALU_PASSB: alu_res = op_b;
            default:   alu_res = op_a + op_b;
        endcase
        case (ex_q.br_kind)
            BR_EQ:   taken = (op_a == rs2_fwd);
            BR_NE:   taken = (op_a != rs2_fwd);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o.valid  = ex_valid_q & taken;
    assign redirect_o.target = ex_q.pc + ex_q.imm;

    always_comb begin
        wb_d.valid  = ex_valid_q;
        wb_d.pc     = ex_q.pc;
        wb_d.instr  = ex_q.instr;
        wb_d.rd_idx = ex_q.rd_idx;
        wb_d.wb_en  = ex_q.wb_en;
        wb_d.result = (ex_q.br_kind == BR_JAL) ? ex_q.pc + XLEN'(4) : alu_res;
    end

    always_comb begin
        wb_o       = wb_q;
        wb_o.valid = wb_valid_q;
    end

endmodule

`default_nettype wire

/* src/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; #(
    parameter int unsigned     AXI_ADDR_WIDTH = 64,
    parameter int unsigned     AXI_ID_WIDTH   = 4,
    parameter logic [XLEN-1:0] RESET_PC       = '0
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    input  wire logic                 axi_ar_ready_i,
    output logic                      axi_ar_valid_o,
    output logic [AXI_ADDR_WIDTH-1:0] axi_ar_addr_o,
    output logic [AXI_ID_WIDTH-1:0]   axi_ar_id_o,
    input  wire logic                 axi_r_valid_i,
    output logic                      axi_r_ready_o,
    input  wire logic [63:0]          axi_r_data_i,
    output logic                      commit_valid_o,
    output logic [XLEN-1:0]           commit_pc_o,
    output instr_t                    commit_instr_o,
    output logic [XLEN-1:0]           reg_a0_o
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    redirect_t redirect;
    wb_t       wb;

    fetch_axi #(
        .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
        .AXI_ID_WIDTH   (AXI_ID_WIDTH),
        .RESET_PC       (RESET_PC)
    ) i_fetch_axi (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .redirect_i     (redirect),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_id_o    (axi_ar_id_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_data_i   (axi_r_data_i),
        .if_id_o        (if_id)
    );

    decode_stage i_decode_stage (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .if_id_i    (if_id),
        .redirect_i (redirect),
        .wb_i       (wb),
        .id_ex_o    (id_ex),
        .reg_a0_o   (reg_a0_o)
    );

    execute_stage i_execute_stage (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .redirect_o (redirect),
        .wb_o       (wb)
    );

    // commit trace straight off the wb register
    assign commit_valid_o = wb.valid;
    assign commit_pc_o    = wb.pc;
    assign commit_instr_o = wb.instr;

endmodule

`default_nettype wire

/* verification/axi_rom_model.sv */
`default_nettype none

module axi_rom_model (
    input  wire logic        clk,
    input  wire logic        arst_n_i,
    input  wire logic        ar_valid_i,
    input  wire logic [63:0] ar_addr_i,
    output logic             ar_ready_o,
    input  wire logic        r_ready_i,
    output logic             r_valid_o,
    output logic [63:0]      r_data_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] LFSR_SEED = 16'd7;

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR_WAIT,
        S_AR_ACK,
        S_R_WAIT,
        S_R_ACK
    } state_e;

    logic [31:0] prog_mem [0:63];
    state_e      state      = S_IDLE;
    logic [15:0] lfsr_q     = LFSR_SEED;
    int unsigned wait_cnt   = 0;
    logic [63:0] addr_q     = '0;
    logic        ready_seen = 1'b0;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit, two bits give 0 to 3 cycles
    task automatic draw_delay(output int unsigned d);
        int unsigned k;
        d = 0;
        for (k = 0; k < 2; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            d = (d << 1) | lfsr_q[0];
        end
    endtask

    // addi x0, x0, <word index> everywhere, harmless if fetched
    task automatic clear_program();
        int unsigned i;
        for (i = 0; i < 64; i++) begin
            prog_mem[i] = {i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
    endtask

    task automatic write_word(input int unsigned idx, input logic [31:0] word);
        prog_mem[idx[5:0]] = word;
    endtask

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
    end

    always begin
        @(posedge clk);
        #2;
        if (!arst_n_i) begin
            state      = S_IDLE;
            ar_ready_o = 1'b0;
            r_valid_o  = 1'b0;
        end else begin
            if (state == S_R_ACK) begin
                if (ready_seen) begin
                    r_valid_o = 1'b0;   // beat taken at the last edge
                    state     = S_IDLE;
                end else begin
                    ready_seen = r_ready_i;
                end
            end
            if (state == S_IDLE && ar_valid_i) begin
                draw_delay(wait_cnt);
                state = S_AR_WAIT;
            end
            if (state == S_AR_WAIT) begin
                if (wait_cnt == 0) begin
                    ar_ready_o = 1'b1;
                    addr_q     = ar_addr_i;
                    state      = S_AR_ACK;
                end else begin
                    wait_cnt--;
                end
            end else if (state == S_AR_ACK) begin
                ar_ready_o = 1'b0;  // address handshake done
                draw_delay(wait_cnt);
                state = S_R_WAIT;
            end
            if (state == S_R_WAIT) begin
                if (wait_cnt == 0) begin
                    r_valid_o  = 1'b1;
                    r_data_o   = {prog_mem[{addr_q[7:3], 1'b1}], prog_mem[{addr_q[7:3], 1'b0}]};
                    ready_seen = r_ready_i;
                    state      = S_R_ACK;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/core_tb.sv */
`default_nettype none

module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned     ADDR_W         = 64;
    localparam int unsigned     ID_W           = 4;
    localparam logic [XLEN-1:0] START_PC       = '0;
    localparam int unsigned     MAX_TESTS      = 8;
    localparam int unsigned     MAX_WORDS      = 12;
    localparam int unsigned     MAX_COMMITS    = 16;
    localparam int unsigned     COMMIT_TIMEOUT = 500;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              ar_ready;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic [ID_W-1:0]   ar_id;
    logic              r_valid;
    logic              r_ready;
    logic [63:0]       r_data;
    logic              commit_valid;
    logic [XLEN-1:0]   commit_pc;
    instr_t            commit_instr;
    logic [XLEN-1:0]   reg_a0;

    string           tbl_name    [MAX_TESTS];
    instr_t          tbl_prog    [MAX_TESTS][MAX_WORDS];
    int unsigned     tbl_words   [MAX_TESTS];
    logic [XLEN-1:0] tbl_pc      [MAX_TESTS][MAX_COMMITS];
    int unsigned     tbl_commits [MAX_TESTS];
    logic [XLEN-1:0] tbl_a0      [MAX_TESTS];
    int unsigned     num_tests  = 0;
    int unsigned     errs       = 0;
    int unsigned     pass_count = 0;
    int unsigned     fail_count = 0;

    always #50 clk = ~clk;

    core_top #(
        .AXI_ADDR_WIDTH (ADDR_W),
        .AXI_ID_WIDTH   (ID_W),
        .RESET_PC       (START_PC)
    ) i_core_top (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_id_o    (ar_id),
        .axi_r_valid_i  (r_valid),
        .axi_r_ready_o  (r_ready),
        .axi_r_data_i   (r_data),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_instr_o (commit_instr),
        .reg_a0_o       (reg_a0)
    );

    axi_rom_model i_axi_rom_model (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_ready_i  (r_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data)
    );

    // rv32i/rv64i base encodings
    function automatic instr_t addi_insn(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instr_t lui_insn(input logic [4:0] rd, input logic [19:0] imm20);
        return {imm20, rd, 7'b0110111};
    endfunction

    function automatic instr_t r_insn(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t b_insn(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic instr_t jal_insn(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic new_test(input string name, input logic [XLEN-1:0] a0);
        tbl_name[num_tests]    = name;
        tbl_a0[num_tests]      = a0;
        tbl_words[num_tests]   = 0;
        tbl_commits[num_tests] = 0;
        num_tests++;
    endtask

    task automatic put_word(input instr_t w);
        int unsigned cur;
        cur = num_tests - 1;
        tbl_prog[cur][tbl_words[cur]] = w;
        tbl_words[cur]++;
    endtask

    task automatic expect_pcs(input int unsigned first, input int unsigned last);
        int unsigned cur;
        int unsigned pc;
        cur = num_tests - 1;
        for (pc = first; pc <= last; pc += 4) begin
            tbl_pc[cur][tbl_commits[cur]] = XLEN'(pc);
            tbl_commits[cur]++;
        end
    endtask

    task automatic define_tests();
        new_test("alu_ops", 64'hffff_ffff_8000_0133);
        put_word(addi_insn(1, 0, 32'h123));
        put_word(addi_insn(2, 0, -5));
        put_word(r_insn(7'h00, 3'b000, 3, 1, 2));    // add
        put_word(r_insn(7'h20, 3'b000, 4, 1, 2));    // sub
        put_word(r_insn(7'h00, 3'b100, 5, 3, 4));    // xor
        put_word(r_insn(7'h00, 3'b110, 6, 5, 1));    // or
        put_word(r_insn(7'h00, 3'b111, 7, 6, 2));    // and
        put_word(lui_insn(8, 20'h80000));            // sign-extends on rv64
        put_word(r_insn(7'h00, 3'b000, 10, 8, 7));
        expect_pcs('h0, 'h20);

        new_test("forwarding", 64'h14);
        put_word(addi_insn(10, 0, 1));
        put_word(addi_insn(10, 10, 2));
        put_word(r_insn(7'h00, 3'b000, 10, 10, 10));
        put_word(addi_insn(11, 10, 7));
        put_word(r_insn(7'h20, 3'b000, 10, 11, 10));
        put_word(r_insn(7'h00, 3'b000, 10, 10, 11));
        put_word(addi_insn(0, 10, 99));              // x0 must stay 0
        put_word(r_insn(7'h00, 3'b000, 10, 10, 0));
        expect_pcs('h0, 'h1c);

        new_test("taken_branches", 64'h21);
        put_word(addi_insn(1, 0, 5));
        put_word(addi_insn(2, 0, 5));
        put_word(b_insn(3'b000, 1, 2, 8));           // beq to 0x10
        put_word(addi_insn(10, 0, 111));
        put_word(addi_insn(10, 0, 1));
        put_word(b_insn(3'b001, 10, 0, 8));          // bne to 0x1c
        put_word(addi_insn(10, 0, 333));
        put_word(jal_insn(5, 8));                    // link 0x20
        put_word(addi_insn(10, 0, 555));
        put_word(r_insn(7'h00, 3'b000, 10, 10, 5));
        expect_pcs('h0, 'h8);
        expect_pcs('h10, 'h14);
        expect_pcs('h1c, 'h1c);
        expect_pcs('h24, 'h24);

        new_test("untaken_branches", 64'h22);
        put_word(addi_insn(1, 0, 3));
        put_word(addi_insn(2, 0, 4));
        put_word(b_insn(3'b000, 1, 2, 16));
        put_word(addi_insn(10, 0, 11));
        put_word(b_insn(3'b001, 1, 1, 16));
        put_word(addi_insn(10, 10, 20));
        put_word(r_insn(7'h00, 3'b000, 10, 10, 1));
        expect_pcs('h0, 'h18);

        new_test("loop_and_jump", 64'hf);
        put_word(addi_insn(10, 0, 0));
        put_word(addi_insn(1, 0, 3));
        put_word(addi_insn(10, 10, 5));
        put_word(addi_insn(1, 1, -1));
        put_word(b_insn(3'b001, 1, 0, -8));          // back to 0x8 while x1 != 0
        put_word(jal_insn(0, 8));
        put_word(addi_insn(10, 0, 99));
        put_word(r_insn(7'h00, 3'b000, 10, 10, 0));
        expect_pcs('h0, 'h4);
        repeat (3) expect_pcs('h8, 'h10);
        expect_pcs('h14, 'h14);
        expect_pcs('h1c, 'h1c);
    endtask

    task automatic check_xlen(input string name, input string what,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("FAIL %s commit instr: expected %h, actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_ar_id(input string name, input logic [ID_W-1:0] exp,
                               input logic [ID_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s ar_id: expected %h, actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic run_test(input int unsigned t);
        logic [XLEN-1:0] got_pc    [MAX_COMMITS];
        instr_t          got_instr [MAX_COMMITS];
        int unsigned     n_got;
        int unsigned     cycles;
        int unsigned     i;
        int unsigned     idx;
        errs   = 0;
        n_got  = 0;
        cycles = 0;
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        i_axi_rom_model.clear_program();
        for (i = 0; i < tbl_words[t]; i++) begin
            i_axi_rom_model.write_word(i, tbl_prog[t][i]);
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (n_got < tbl_commits[t] && cycles < COMMIT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (ar_valid) begin
                check_ar_id(tbl_name[t], '0, ar_id);  // single id for every fetch
            end
            if (commit_valid) begin
                got_pc[n_got]    = commit_pc;
                got_instr[n_got] = commit_instr;
                n_got++;
            end
        end
        if (n_got < tbl_commits[t]) begin
            $display("%s: timed out, only %0d of %0d commits arrived within %0d cycles",
                     tbl_name[t], n_got, tbl_commits[t], COMMIT_TIMEOUT);
            errs++;
        end
        // register file takes the last result on the next edge
        @(posedge clk);
        #1;
        for (i = 0; i < n_got; i++) begin
            check_xlen(tbl_name[t], "commit pc", tbl_pc[t][i], got_pc[i]);
            idx = int'(tbl_pc[t][i] >> 2);
            check_instr(tbl_name[t], tbl_prog[t][idx], got_instr[i]);
        end
        check_xlen(tbl_name[t], "a0", tbl_a0[t], reg_a0);
        if (errs == 0) begin
            $display("test %s ok, %0d commits", tbl_name[t], n_got);
            pass_count++;
        end else begin
            $display("test %s had %0d errors", tbl_name[t], errs);
            fail_count++;
        end
    endtask

    initial begin
        int unsigned t;
        arst_n = 1'b0;
        define_tests();
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d passed, %0d failed", num_tests, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/core_pkg.sv
src/fetch_axi.sv
src/decode_stage.sv
src/execute_stage.sv
src/core_top.sv
verification/axi_rom_model.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: core_rv64

sources:
  - src/core_pkg.sv
  - src/fetch_axi.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/core_top.sv
  - target: test
    files:
      - verification/axi_rom_model.sv
      - verification/core_tb.sv
